// File: addr_align.sv
module addr_align
    import rv32_mem_pkg::*;
    import lsu_bus_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  mem_op_t           op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  word_t             wdata_i,

    output logic [ADDR_W-1:0] word_addr_o,
    output lane_mask_t        mask_o,
    output word_t             wdata_o
);

    logic [OFFS_W-1:0] offs;
    lane_mask_t        size_mask;

    assign offs = addr_i[OFFS_W-1:0];

    // byte address rounded down to the word
    assign word_addr_o = {addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};

    always_comb begin : size_decode
        if (op_i.is_store) begin
            case (store_funct3_e'(op_i.funct3))
                sw:      size_mask = '1;
                sh:      size_mask = lane_mask_t'(2'b11);
                default: size_mask = lane_mask_t'(1'b1); // sb
            endcase
        end
        else begin
            case (load_funct3_e'(op_i.funct3))
                lw:       size_mask = '1;
                lh, lhu:  size_mask = lane_mask_t'(2'b11);
                default:  size_mask = lane_mask_t'(1'b1); // lb, lbu
            endcase
        end
    end

    // aligned accesses only, so the shift never drops a lane
    assign mask_o = size_mask << offs;

    // move store bytes onto their lanes
    assign wdata_o = op_i.is_store ? (wdata_i << {offs, 3'b000}) : '0;

endmodule : addr_align

// File: files.f
rv32_mem_pkg.sv
lsu_bus_pkg.sv
addr_align.sv
stage_reg.sv
wb_data_port.sv
load_extract.sv
lsu_top.sv
wb_mem_model.sv
tb_lsu_top.sv

// File: load_extract.sv
module load_extract
    import rv32_mem_pkg::*;
    import lsu_bus_pkg::*;
(
    input  word_t      raw_i,
    input  lane_mask_t mask_i,
    input  mem_op_t    op_i,

    output word_t      data_o
);

    logic [7:0]  byte_v;
    logic [15:0] half_v;

    always_comb begin : lane_select
        case (mask_i)
            4'b0010: byte_v = raw_i[15:8];
            4'b0100: byte_v = raw_i[23:16];
            4'b1000: byte_v = raw_i[31:24];
            default: byte_v = raw_i[7:0];
        endcase
    end

    // halves sit at offset 0 or 2 only
    assign half_v = mask_i[2] ? raw_i[31:16] : raw_i[15:0];

    always_comb begin : extend
        if (op_i.is_store) begin
            data_o = raw_i;
        end
        else begin
            case (load_funct3_e'(op_i.funct3))
                lb:      data_o = {{(DATA_W-8){byte_v[7]}}, byte_v};
                lbu:     data_o = {{(DATA_W-8){1'b0}}, byte_v};
                lh:      data_o = {{(DATA_W-16){half_v[15]}}, half_v};
                lhu:     data_o = {{(DATA_W-16){1'b0}}, half_v};
                default: data_o = raw_i; // lw
            endcase
        end
    end

endmodule : load_extract

// File: lsu_bus_pkg.sv
package lsu_bus_pkg;

    localparam int DATA_W = 32; // data bus width
    localparam int LANES  = DATA_W / 8; // byte lanes per word
    localparam int OFFS_W = 2; // byte offset bits within a word

    typedef logic [DATA_W-1:0] word_t; // bus and register data
    typedef logic [LANES-1:0]  lane_mask_t; // wishbone sel, lane picks

endpackage : lsu_bus_pkg

// File: lsu_top.sv
module lsu_top
    import rv32_mem_pkg::*;
    import lsu_bus_pkg::*;
#(
    parameter int ADDR_W = 32,
    parameter int TAG_W  = 5
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              req_valid_i,
    input  mem_op_t           req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  word_t             req_wdata_i,
    input  logic [TAG_W-1:0]  req_tag_i,
    output logic              req_ready_o,

    output logic              resp_valid_o,
    output logic [TAG_W-1:0]  resp_tag_o,
    output word_t             resp_data_o,
    input  logic              resp_ready_i,

    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output word_t             wb_dat_o,
    output lane_mask_t        wb_sel_o,
    input  word_t             wb_dat_i,
    input  logic              wb_ack_i
);

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        lane_mask_t        mask;
        word_t             wdata;
        mem_op_t           op;
        logic [TAG_W-1:0]  tag;
    } req_payload_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        word_t            data;
    } resp_payload_t;

    req_payload_t  req_d, req_q;
    resp_payload_t resp_d, resp_q;
    logic          req_q_valid, port_ready;
    logic          slot_valid, slot_ready;
    word_t         slot_raw;
    lane_mask_t    slot_mask;
    mem_op_t       slot_op;
    logic [TAG_W-1:0] slot_tag;

    assign req_d.op  = req_op_i;
    assign req_d.tag = req_tag_i;

    addr_align #(.ADDR_W(ADDR_W)) align_i (
        .op_i        (req_op_i),
        .addr_i      (req_addr_i),
        .wdata_i     (req_wdata_i),
        .word_addr_o (req_d.addr),
        .mask_o      (req_d.mask),
        .wdata_o     (req_d.wdata)
    );

    stage_reg #(.payload_t(req_payload_t)) req_reg (
        .clk     (clk),
        .rst     (rst),
        .valid_i (req_valid_i),
        .data_i  (req_d),
        .ready_o (req_ready_o),
        .valid_o (req_q_valid),
        .data_o  (req_q),
        .ready_i (port_ready)
    );

    wb_data_port #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) port_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (req_q_valid),
        .word_addr_i (req_q.addr),
        .mask_i      (req_q.mask),
        .wdata_i     (req_q.wdata),
        .op_i        (req_q.op),
        .tag_i       (req_q.tag),
        .ready_o     (port_ready),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .wb_sel_o    (wb_sel_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .valid_o     (slot_valid),
        .raw_o       (slot_raw),
        .mask_o      (slot_mask),
        .op_o        (slot_op),
        .tag_o       (slot_tag),
        .ready_i     (slot_ready)
    );

    load_extract extract_i (
        .raw_i  (slot_raw),
        .mask_i (slot_mask),
        .op_i   (slot_op),
        .data_o (resp_d.data)
    );

    assign resp_d.tag = slot_tag;

    stage_reg #(.payload_t(resp_payload_t)) resp_reg (
        .clk     (clk),
        .rst     (rst),
        .valid_i (slot_valid),
        .data_i  (resp_d),
        .ready_o (slot_ready),
        .valid_o (resp_valid_o),
        .data_o  (resp_q),
        .ready_i (resp_ready_i)
    );

    assign resp_tag_o  = resp_q.tag;
    assign resp_data_o = resp_q.data;

endmodule : lsu_top

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_lsu_top -o tb_lsu_top

out=$(./obj_dir/tb_lsu_top)
echo "$out"

if echo "$out" | grep -q "No errors"; then
    exit 0
fi
exit 1

// File: rv32_mem_pkg.sv
package rv32_mem_pkg;

    // funct3 codes of the RV32I load group
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // funct3 codes of the RV32I store group
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // one memory operation as it travels down the pipe
    // funct3 is a load code when is_store is low, a store code otherwise
    typedef struct packed {
        logic       is_store;
        logic [2:0] funct3;
    } mem_op_t;

endpackage : rv32_mem_pkg

// File: stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,

    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    logic     valid_q;
    payload_t data_q;

    // load when empty or when the held item leaves this edge
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk, posedge rst) begin : valid_reg
        if (rst) begin
            valid_q <= 1'b0;
        end
        else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin : data_reg
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule : stage_reg

// File: tb_lsu_top.sv
module tb_lsu_top
    import rv32_mem_pkg::*;
    import lsu_bus_pkg::*;
;

    localparam int ADDR_W     = 32;
    localparam int TAG_W      = 5;
    localparam int SEED       = 85628;
    localparam int N_STORE    = 7; // sb x4, sh x2, sw
    localparam int N_LOAD     = 13; // legal load kind and offset pairs
    localparam int N_STREAM   = 40;
    localparam int N_REQ      = N_STORE + 2 * N_LOAD + N_STREAM;
    localparam int MAX_CYCLES = 20 * N_REQ + 200;

    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        lane_mask_t        sel;
        logic              we;
        word_t             dat;
    } bus_exp_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        word_t            data;
    } resp_exp_t;

    logic              clk;
    logic              rst;
    logic              req_valid_i;
    mem_op_t           req_op_i;
    logic [ADDR_W-1:0] req_addr_i;
    word_t             req_wdata_i;
    logic [TAG_W-1:0]  req_tag_i;
    logic              req_ready_o;
    logic              resp_valid_o;
    logic [TAG_W-1:0]  resp_tag_o;
    word_t             resp_data_o;
    logic              resp_ready_i;
    logic              wb_cyc_o;
    logic              wb_stb_o;
    logic              wb_we_o;
    logic [ADDR_W-1:0] wb_adr_o;
    word_t             wb_dat_o;
    lane_mask_t        wb_sel_o;
    word_t             wb_dat_i;
    logic              wb_ack_i;

    word_t            ref_mem [256]; // expected memory contents
    bus_exp_t         bus_q[$];
    resp_exp_t        resp_q[$];
    logic [TAG_W-1:0] next_tag;
    logic             bp_on; // random back-pressure on the response side
    int               err_cnt;
    int               err_base;
    int               tests_run;
    int               tests_failed;
    int               cycles;

    lsu_top #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) lsu_top_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_tag_i    (req_tag_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_tag_o   (resp_tag_o),
        .resp_data_o  (resp_data_o),
        .resp_ready_i (resp_ready_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_o     (wb_dat_o),
        .wb_sel_o     (wb_sel_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i)
    );

    wb_mem_model #(.ADDR_W(ADDR_W)) slave (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc_o),
        .wb_stb_i (wb_stb_o),
        .wb_we_i  (wb_we_o),
        .wb_adr_i (wb_adr_o),
        .wb_dat_i (wb_dat_o),
        .wb_sel_i (wb_sel_o),
        .wb_dat_o (wb_dat_i),
        .wb_ack_o (wb_ack_i)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    bus_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_sel_o)
            && $stable(wb_we_o) && $stable(wb_dat_o)))
    else begin
        err_cnt++;
        $display("ERROR %0t: bus fields changed while waiting for ack", $time);
    end

    adr_aligned: assert property (@(posedge clk) disable iff (rst)
        wb_cyc_o |-> (wb_adr_o[1:0] == 2'b00))
    else begin
        err_cnt++;
        $display("ERROR %0t: wb_adr_o %h not word aligned", $time, wb_adr_o);
    end

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_tag_o)
            && $stable(resp_data_o)))
    else begin
        err_cnt++;
        $display("ERROR %0t: response changed while stalled", $time);
    end

    function automatic int size_of(input logic [2:0] f3);
        return (f3[1:0] == 2'b10) ? 4 : (f3[1:0] == 2'b01) ? 2 : 1;
    endfunction

    function automatic logic [2:0] load_code(input int k);
        case (k)
            0:       return lb;
            1:       return lh;
            2:       return lw;
            3:       return lbu;
            default: return lhu;
        endcase
    endfunction

    // drives one request at +1 and waits for the transfer edge
    task automatic send(input logic st, input logic [2:0] f3, input int idx,
                        input int offs, input word_t wdata);
        mem_op_t    op;
        lane_mask_t sel;
        word_t      lane_dat;
        word_t      shifted;
        resp_exp_t  r;
        bus_exp_t   b;
        logic       acc;
        op.is_store = st;
        op.funct3   = f3;
        sel         = lane_mask_t'(((1 << size_of(f3)) - 1) << offs);
        lane_dat    = wdata << (8 * offs);
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = ADDR_W'(idx * 4 + offs);
        req_wdata_i = wdata;
        req_tag_i   = next_tag;
        do begin
            @(negedge clk);
            acc = req_ready_o;
            @(posedge clk);
        end while (!acc);
        shifted = ref_mem[idx] >> (8 * offs);
        r.tag   = next_tag;
        if (st) begin
            r.data = '0;
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) ref_mem[idx][8*i +: 8] = lane_dat[8*i +: 8];
            end
        end
        else begin
            case (load_funct3_e'(f3))
                lb:      r.data = {{24{shifted[7]}}, shifted[7:0]};
                lbu:     r.data = {24'h0, shifted[7:0]};
                lh:      r.data = {{16{shifted[15]}}, shifted[15:0]};
                lhu:     r.data = {16'h0, shifted[15:0]};
                default: r.data = ref_mem[idx];
            endcase
        end
        b.adr = ADDR_W'(idx * 4);
        b.sel = sel;
        b.we  = st;
        b.dat = lane_dat;
        bus_q.push_back(b);
        resp_q.push_back(r);
        next_tag = next_tag + 1'b1;
        #1 req_valid_i = 1'b0;
    endtask

    task automatic end_test(input string name);
        while (resp_q.size() != 0 || bus_q.size() != 0) @(posedge clk);
        tests_run++;
        if (err_cnt != err_base) tests_failed++;
        $display("test %-10s %s, %0d errors", name,
                 (err_cnt == err_base) ? "passed" : "FAILED", err_cnt - err_base);
        err_base = err_cnt;
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin : bus_check
        bus_exp_t b;
        if (!rst && wb_cyc_o && wb_stb_o && wb_ack_i) begin
            if (bus_q.size() == 0) begin
                err_cnt++;
                $display("bus cycle at %0t without an outstanding request", $time);
            end
            else begin
                b = bus_q.pop_front();
                assert (wb_adr_o == b.adr && wb_sel_o == b.sel && wb_we_o == b.we) else begin
                    err_cnt++;
                    $display("ERROR %0t: bus adr %h sel %b we %b, expected %h %b %b", $time,
                             wb_adr_o, wb_sel_o, wb_we_o, b.adr, b.sel, b.we);
                end
                if (b.we) begin
                    assert (wb_dat_o == b.dat) else begin
                        err_cnt++;
                        $display("ERROR %0t: wb_dat_o %h, expected %h", $time, wb_dat_o, b.dat);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin : resp_check
        resp_exp_t r;
        if (!rst && resp_valid_o && resp_ready_i) begin
            if (resp_q.size() == 0) begin
                err_cnt++;
                $display("extra response at %0t with tag %0d", $time, resp_tag_o);
            end
            else begin
                r = resp_q.pop_front();
                assert (resp_tag_o == r.tag && resp_data_o == r.data) else begin
                    err_cnt++;
                    $display("ERROR %0t: response tag %0d data %h, expected %0d %h", $time,
                             resp_tag_o, resp_data_o, r.tag, r.data);
                end
            end
        end
    end

    always @(posedge clk) begin : ready_drive
        #1 resp_ready_i = bp_on ? ($urandom % 3 != 0) : 1'b1;
    end

    always @(posedge clk) begin : watchdog
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d responses never arrived", cycles,
                     resp_q.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin : main
        logic [2:0] f3;
        int         idx;
        int         kind;
        int         sz;
        void'($urandom(SEED));
        rst          = 1'b1;
        req_valid_i  = 1'b0;
        req_op_i     = '0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        req_tag_i    = '0;
        resp_ready_i = 1'b1;
        next_tag     = '0;
        bp_on        = 1'b0;
        err_cnt      = 0;
        err_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        assert (!resp_valid_o && !wb_cyc_o && !wb_stb_o && !wb_we_o && req_ready_o) else begin
            err_cnt++;
            $display("ERROR %0t: outputs not idle after reset", $time);
        end
        for (int i = 0; i < 256; i++) ref_mem[i] = slave.mem[i];
        end_test("reset");

        for (int o = 0; o < 4; o++) send(1'b1, sb, $urandom % 256, o, $urandom);
        send(1'b1, sh, $urandom % 256, 0, $urandom);
        send(1'b1, sh, $urandom % 256, 2, $urandom);
        send(1'b1, sw, $urandom % 256, 0, $urandom);
        end_test("stores");

        for (int k = 0; k < 5; k++) begin
            f3 = load_code(k);
            for (int o = 0; o < 4; o += size_of(f3)) begin
                idx = $urandom % 256;
                send(1'b1, sw, idx, 0, $urandom); // fresh word first
                send(1'b0, f3, idx, o, '0);
            end
        end
        end_test("loads");

        bp_on = 1'b1;
        for (int n = 0; n < N_STREAM; n++) begin
            kind = $urandom % 8;
            f3   = (kind < 5) ? load_code(kind) : 3'(kind - 5);
            sz   = size_of(f3);
            send(kind >= 5, f3, $urandom % 256, ($urandom % 4) / sz * sz, $urandom);
        end
        bp_on = 1'b0;
        end_test("ordering");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_lsu_top

// File: wb_data_port.sv
module wb_data_port
    import rv32_mem_pkg::*;
    import lsu_bus_pkg::*;
#(
    parameter int ADDR_W = 32,
    parameter int TAG_W  = 5
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              valid_i,
    input  logic [ADDR_W-1:0] word_addr_i,
    input  lane_mask_t        mask_i,
    input  word_t             wdata_i,
    input  mem_op_t           op_i,
    input  logic [TAG_W-1:0]  tag_i,
    output logic              ready_o,

    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output word_t             wb_dat_o,
    output lane_mask_t        wb_sel_o,
    input  word_t             wb_dat_i,
    input  logic              wb_ack_i,

    output logic              valid_o,
    output word_t             raw_o,
    output lane_mask_t        mask_o,
    output mem_op_t           op_o,
    output logic [TAG_W-1:0]  tag_o,
    input  logic              ready_i
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        BUSY = 2'b01, // bus cycle open
        DONE = 2'b10 // result slot full
    } state_e;

    state_e            state;
    logic [ADDR_W-1:0] adr_q;
    word_t             dat_q;
    lane_mask_t        sel_q;
    mem_op_t           op_q;
    logic [TAG_W-1:0]  tag_q;
    word_t             raw_q;

    always_ff @(posedge clk, posedge rst) begin : fsm
        if (rst) begin
            state <= IDLE;
        end
        else begin
            case (state)
                IDLE:    if (valid_i) state <= BUSY;
                BUSY:    if (wb_ack_i) state <= DONE;
                DONE:    if (ready_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request fields stay put for the whole bus cycle
    always_ff @(posedge clk) begin : req_capture
        if (state == IDLE && valid_i) begin
            adr_q <= word_addr_i;
            dat_q <= wdata_i;
            sel_q <= mask_i;
            op_q  <= op_i;
            tag_q <= tag_i;
        end
    end

    always_ff @(posedge clk) begin : result_capture
        if (state == BUSY && wb_ack_i) begin
            raw_q <= op_q.is_store ? '0 : wb_dat_i; // stores answer zero
        end
    end

    assign ready_o = (state == IDLE);

    assign wb_cyc_o = (state == BUSY);
    assign wb_stb_o = (state == BUSY);
    assign wb_we_o  = (state == BUSY) && op_q.is_store;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;
    assign wb_sel_o = sel_q;

    assign valid_o = (state == DONE);
    assign raw_o   = raw_q;
    assign mask_o  = sel_q;
    assign op_o    = op_q;
    assign tag_o   = tag_q;

endmodule : wb_data_port

// File: wb_mem_model.sv
module wb_mem_model
    import lsu_bus_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  word_t             wb_dat_i,
    input  lane_mask_t        wb_sel_i,
    output word_t             wb_dat_o,
    output logic              wb_ack_o
);

    word_t      mem [256];
    logic [7:0] idx;
    logic [1:0] wait_cnt;
    logic [1:0] wait_len; // wait cycles before the next ack

    assign idx      = wb_adr_i[9:2];
    assign wb_dat_o = mem[idx];
    assign wb_ack_o = wb_cyc_i && wb_stb_i && (wait_cnt == wait_len);

    always_ff @(posedge clk, posedge rst) begin : wait_ctrl
        if (rst) begin
            wait_cnt <= '0;
            wait_len <= '0;
        end
        else if (wb_ack_o) begin
            wait_cnt <= '0;
            wait_len <= 2'($urandom % 4);
        end
        else if (wb_cyc_i && wb_stb_i) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always @(posedge clk) begin : mem_write
        if (rst) begin
            for (int i = 0; i < 256; i++) mem[i] <= $urandom; // random contents
        end
        else if (wb_ack_o && wb_we_i) begin
            for (int i = 0; i < LANES; i++) begin
                if (wb_sel_i[i]) mem[idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
        end
    end

endmodule : wb_mem_model
